//--- tb.f
+incdir+.
rv_core_pkg.sv
rv_stage_if.sv
rv_fetch.sv
rv_regfile.sv
rv_decode.sv
rv_execute.sv
rv_memory.sv
rv_core.sv
tb_rv_core.sv

//--- tb_rv_model.svh
// Program builders and ISA reference model included inside the core testbench module
`ifndef TB_RV_MODEL_SVH
`define TB_RV_MODEL_SVH

function automatic logic [31:0] enc_r(input logic [6:0] f7, input int rs2, input int rs1,
                                      input int f3, input int rd);
    return {f7, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
endfunction

function automatic logic [31:0] enc_i(input int imm, input int rs1, input int f3, input int rd,
                                      input logic [6:0] opc);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
endfunction

function automatic logic [31:0] enc_s(input int imm, input int rs2, input int rs1);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
endfunction

// Branch that skips exactly one instruction
function automatic logic [31:0] enc_b8(input int f3, input int rs1, input int rs2);
    return {7'b0, rs2[4:0], rs1[4:0], f3[2:0], 5'b01000, 7'b1100011};
endfunction

// Append one instruction after enough NOPs for its sources to be three slots old
task automatic put(input logic [31:0] instr, input int rs1, input int rs2, input int rd);
    while (prog_len < ready[rs1] || prog_len < ready[rs2]) begin
        prog[prog_len] = 32'h0000_0013;
        prog_len++;
    end
    prog[prog_len] = instr;
    prog_len++;
    if (rd != 0) begin
        ready[rd] = prog_len + 2;
    end
endtask

task automatic store_reg(input int rs);
    put(enc_s(st_addr, rs, 0), 0, rs, 0);
    st_addr += 4;
endtask

task automatic build_program();
    int f3_tab [10] = '{0, 0, 7, 6, 4, 2, 0, 7, 6, 4};
    int op;
    int rd;
    int rs1;
    int rs2;
    int imm;
    prog_len = 0;
    st_addr  = 32'h400;
    for (int r = 0; r < 32; r++) ready[r] = 0;
    for (int r = 1; r < 32; r++) put(enc_i($random(seed), 0, 0, r, 7'b0010011), 0, 0, r);
    // Random ALU mix with x0 as a possible destination
    for (int k = 0; k < 48; k++) begin
        op  = $unsigned($random(seed)) % 10;
        rd  = $unsigned($random(seed)) % 32;
        rs1 = $unsigned($random(seed)) % 32;
        rs2 = $unsigned($random(seed)) % 32;
        imm = $random(seed);
        if (op < 6) begin
            put(enc_r((op == 1) ? 7'h20 : 7'h00, rs2, rs1, f3_tab[op], rd), rs1, rs2, rd);
        end else begin
            put(enc_i(imm, rs1, f3_tab[op], rd, 7'b0010011), rs1, 0, rd);
        end
    end
    // Nonzero results aimed at x0
    put(enc_i(32'h5a5, 0, 6, 0, 7'b0010011), 0, 0, 0);
    put(enc_r(7'h00, 1, 2, 4, 0), 2, 1, 0);
    for (int r = 0; r < 32; r++) store_reg(r);
    // Loads from the preloaded low region followed by xori and two stores
    for (int k = 0; k < 8; k++) begin
        rd  = 1 + $unsigned($random(seed)) % 31;
        rs2 = 1 + $unsigned($random(seed)) % 31;
        imm = ($unsigned($random(seed)) % 256) * 4;
        put(enc_i(imm, 0, 2, rd, 7'b0000011), 0, 0, rd);
        put(enc_i($random(seed), rd, 4, rs2, 7'b0010011), rd, 0, rs2);
        store_reg(rd);
        store_reg(rs2);
    end
    // Bit 0 of k compares a register with itself and bit 1 picks bne
    for (int k = 0; k < 8; k++) begin
        rs1 = 1 + $unsigned($random(seed)) % 31;
        rs2 = k[0] ? rs1 : 1 + $unsigned($random(seed)) % 31;
        put(enc_b8(k[1] ? 1 : 0, rs1, rs2), rs1, rs2, 0);
        store_reg(rs1);
    end
    for (int r = 0; r < 32; r++) store_reg(r);
    put(enc_s(HALT_ADDR, 0, 0), 0, 0, 0);
    put(32'h0000_0063, 0, 0, 0);
endtask

// Architectural run of the program that fills the expected store list
function automatic void run_model();
    logic [31:0] x [32];
    logic [31:0] md [512];
    logic [31:0] pc;
    logic [31:0] pc_n;
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] res;
    logic [31:0] addr;
    logic        wr;
    for (int r = 0; r < 32; r++) x[r] = '0;
    md      = dmem;
    pc      = RESET_PC;
    exp_cnt = 0;
    for (int step = 0; step < 8192; step++) begin
        ins  = prog[(pc - RESET_PC) >> 2];
        a    = x[ins[19:15]];
        b    = x[ins[24:20]];
        imm  = {{20{ins[31]}}, ins[31:20]};
        pc_n = pc + 4;
        wr   = 1'b0;
        res  = '0;
        case (ins[6:0])
            7'b0110011, 7'b0010011: begin
                if (!ins[5]) begin
                    b = imm;
                end
                wr = 1'b1;
                case (ins[14:12])
                    3'b000:  res = (ins[5] && ins[30]) ? a - b : a + b;
                    3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    3'b100:  res = a ^ b;
                    3'b110:  res = a | b;
                    default: res = a & b;
                endcase
            end
            7'b0000011: begin
                addr = a + imm;
                res  = md[addr[10:2]];
                wr   = 1'b1;
            end
            7'b0100011: begin
                addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                exp_addr[exp_cnt] = addr;
                exp_data[exp_cnt] = b;
                exp_slot[exp_cnt] = (pc - RESET_PC) >> 2;
                exp_cnt++;
                if (addr == HALT_ADDR) begin
                    return;
                end
                md[addr[10:2]] = b;
            end
            7'b1100011: begin
                if ((a == b) != ins[12]) begin
                    pc_n = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            default: ;
        endcase
        if (wr && ins[11:7] != 5'd0) begin
            x[ins[11:7]] = res;
        end
        pc = pc_n;
    end
endfunction

`endif

//--- tb_rv_core.sv
// Top-level testbench for the core that runs random programs and checks every store
`timescale 1ns/10ps

module tb_rv_core;
    import rv_core_pkg::*;

    localparam pc_t         RESET_PC  = 32'h0000_0040;
    localparam logic [31:0] HALT_ADDR = 32'h0000_07fc;

    logic        clk_i;
    logic        rst_n_i;
    pc_t         imem_addr_o;
    instr_t      imem_data_i;
    logic        mem_read_o;
    logic        mem_write_o;
    xlen_t       mem_addr_o;
    xlen_t       mem_wdata_o;
    xlen_t       mem_rdata_i;
    logic [31:0] imem_word;

    logic [31:0] prog [1024];
    logic [31:0] dmem [512];
    int          ready [32];
    int          prog_len;
    int          st_addr;
    integer      seed;
    logic [31:0] exp_addr [256];
    logic [31:0] exp_data [256];
    int          exp_slot [256];
    int          fetch_cycle [1024];
    int          exp_cnt     = 0;
    int          st_idx      = 0;
    int          cycle       = 0;
    int          limit       = 0;
    int          value_errs  = 0;
    int          stream_errs = 0;
    int          timing_errs = 0;

    `include "tb_rv_model.svh"

    rv_core #(
        .RESET_PC (RESET_PC)
    ) i_dut (
        .clk_i       (clk_i      ),
        .rst_n_i     (rst_n_i    ),
        .imem_addr_o (imem_addr_o),
        .imem_data_i (imem_data_i),
        .mem_read_o  (mem_read_o ),
        .mem_write_o (mem_write_o),
        .mem_addr_o  (mem_addr_o ),
        .mem_wdata_o (mem_wdata_o),
        .mem_rdata_i (mem_rdata_i)
    );

    // Both memories answer in the same cycle, data only on a read
    assign imem_word   = imem_addr_o - RESET_PC;
    assign imem_data_i = prog[imem_word[11:2]];
    assign mem_rdata_i = mem_read_o ? dmem[mem_addr_o[10:2]] : '0;

    always @(posedge clk_i) begin
        if (rst_n_i && mem_write_o) begin
            dmem[mem_addr_o[10:2]] <= mem_wdata_o;
        end
    end

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    task automatic check_store();
        if (st_idx >= exp_cnt) begin
            $display("Unexpected extra store to %08h at cycle %0d", mem_addr_o, cycle);
            stream_errs++;
        end else begin
            if (mem_addr_o !== exp_addr[st_idx]) begin
                $display("FAIL mem_addr_o: got %08h expected %08h (store %0d)",
                         mem_addr_o, exp_addr[st_idx], st_idx);
                value_errs++;
            end
            if (mem_wdata_o !== exp_data[st_idx]) begin
                $display("FAIL mem_wdata_o: got %08h expected %08h (store %0d)",
                         mem_wdata_o, exp_data[st_idx], st_idx);
                value_errs++;
            end
            if (cycle - fetch_cycle[exp_slot[st_idx]] != 3) begin
                $display("Store %0d came %0d cycles after its fetch instead of 3",
                         st_idx, cycle - fetch_cycle[exp_slot[st_idx]]);
                timing_errs++;
            end
            st_idx++;
        end
    endtask

    // Reset state and the first cycles after release
    always @(negedge clk_i) begin
        if (cycle == 0 && imem_addr_o !== RESET_PC) begin
            $display("FAIL imem_addr_o: got %08h expected %08h", imem_addr_o, RESET_PC);
            value_errs++;
        end
        if (cycle < 3 && mem_write_o !== 1'b0) begin
            $display("FAIL mem_write_o: got %h expected 0", mem_write_o);
            value_errs++;
        end
        if (cycle < 3 && mem_read_o !== 1'b0) begin
            $display("FAIL mem_read_o: got %h expected 0", mem_read_o);
            value_errs++;
        end
    end

    // Cycle 0 is the first fetch after reset release
    always @(posedge clk_i) begin
        if (rst_n_i) begin
            fetch_cycle[imem_word[11:2]] = cycle;
            if (mem_write_o === 1'b1) begin
                check_store();
            end
            cycle++;
        end
    end

    initial begin
        rst_n_i = 1'b0;
        seed    = 32'h465aaa88;
        for (int i = 0; i < 512; i++) dmem[i] = $random(seed);
        for (int i = 0; i < 1024; i++) prog[i] = 32'h0000_0013;
        build_program();
        run_model();
        limit = 20 * prog_len + 100;
        repeat (8) @(posedge clk_i);
        rst_n_i <= 1'b1;
        while (st_idx < exp_cnt && cycle < limit) @(negedge clk_i);
        // Let any stray store behind the halt show up
        repeat (12) @(negedge clk_i);
        if (cycle >= limit) begin
            $display("Timeout at cycle %0d before the halt store", cycle);
            stream_errs++;
        end
        if (st_idx < exp_cnt) begin
            $display("Missing stores: saw %0d of %0d", st_idx, exp_cnt);
            stream_errs++;
        end
        $display("Errors: value %0d, store stream %0d, timing %0d (%0d stores, %0d instructions)",
                 value_errs, stream_errs, timing_errs, st_idx, prog_len);
        if (value_errs + stream_errs + timing_errs == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- rv_core.sv
// Five-stage integer core top level, external instruction and data memories
`timescale 1ns/10ps

module rv_core #(
    parameter rv_core_pkg::pc_t RESET_PC = '0
) (
    input  logic                clk_i,
    input  logic                rst_n_i,
    output rv_core_pkg::pc_t    imem_addr_o,
    input  rv_core_pkg::instr_t imem_data_i,
    output logic                mem_read_o,
    output logic                mem_write_o,
    output rv_core_pkg::xlen_t  mem_addr_o,
    output rv_core_pkg::xlen_t  mem_wdata_o,
    input  rv_core_pkg::xlen_t  mem_rdata_i
);
    import rv_core_pkg::*;

    // Fetch to decode
    pc_t     fd_pc;
    instr_t  fd_instr;
    logic    branch_taken;
    pc_t     branch_target;

    // Register file ports
    rf_idx_t rs1_idx;
    rf_idx_t rs2_idx;
    xlen_t   rs1_val;
    xlen_t   rs2_val;
    logic    wb_we;
    rf_idx_t wb_rd;
    xlen_t   wb_data;

    id_ex_if  u_id_ex ();
    ex_mem_if u_ex_mem ();

    rv_fetch #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk_i           (clk_i        ),
        .rst_n_i         (rst_n_i      ),
        .branch_taken_i  (branch_taken ),
        .branch_target_i (branch_target),
        .imem_addr_o     (imem_addr_o  ),
        .imem_data_i     (imem_data_i  ),
        .pc_o            (fd_pc        ),
        .instr_o         (fd_instr     )
    );

    rv_regfile u_regfile (
        .clk_i     (clk_i  ),
        .rst_n_i   (rst_n_i),
        .rs1_idx_i (rs1_idx),
        .rs2_idx_i (rs2_idx),
        .rs1_val_o (rs1_val),
        .rs2_val_o (rs2_val),
        .wb_we_i   (wb_we  ),
        .wb_rd_i   (wb_rd  ),
        .wb_data_i (wb_data)
    );

    rv_decode u_decode (
        .clk_i           (clk_i        ),
        .rst_n_i         (rst_n_i      ),
        .pc_i            (fd_pc        ),
        .instr_i         (fd_instr     ),
        .rs1_idx_o       (rs1_idx      ),
        .rs2_idx_o       (rs2_idx      ),
        .rs1_val_i       (rs1_val      ),
        .rs2_val_i       (rs2_val      ),
        .branch_taken_o  (branch_taken ),
        .branch_target_o (branch_target),
        .ex              (u_id_ex.src  )
    );

    rv_execute u_execute (
        .clk_i   (clk_i       ),
        .rst_n_i (rst_n_i     ),
        .id      (u_id_ex.dst ),
        .mem     (u_ex_mem.src)
    );

    rv_memory u_memory (
        .clk_i       (clk_i       ),
        .rst_n_i     (rst_n_i     ),
        .ex          (u_ex_mem.dst),
        .mem_read_o  (mem_read_o  ),
        .mem_write_o (mem_write_o ),
        .mem_addr_o  (mem_addr_o  ),
        .mem_wdata_o (mem_wdata_o ),
        .mem_rdata_i (mem_rdata_i ),
        .wb_we_o     (wb_we       ),
        .wb_rd_o     (wb_rd       ),
        .wb_data_o   (wb_data     )
    );

endmodule

//--- rv_memory.sv
// Memory stage: data-memory port drive and the memory/writeback register
`timescale 1ns/10ps

module rv_memory (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    ex_mem_if.dst                ex,
    output logic                 mem_read_o,
    output logic                 mem_write_o,
    output rv_core_pkg::xlen_t   mem_addr_o,
    output rv_core_pkg::xlen_t   mem_wdata_o,
    input  rv_core_pkg::xlen_t   mem_rdata_i,
    output logic                 wb_we_o,
    output rv_core_pkg::rf_idx_t wb_rd_o,
    output rv_core_pkg::xlen_t   wb_data_o
);
    import rv_core_pkg::*;

    xlen_t wb_sel;

    // Memory answers in the same cycle
    assign mem_read_o  = ex.mem_read;
    assign mem_write_o = ex.mem_write;
    assign mem_addr_o  = ex.alu_result;
    assign mem_wdata_o = ex.store_data;

    assign wb_sel = ex.mem_read ? mem_rdata_i : ex.alu_result;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_we_o <= 1'b0;
        end else begin
            wb_we_o <= ex.reg_write;
        end
    end

    always_ff @(posedge clk_i) begin
        wb_rd_o   <= ex.rd;
        wb_data_o <= wb_sel;
    end

endmodule

//--- rv_execute.sv
// Execute stage: operand select, ALU and the execute/memory register
`timescale 1ns/10ps

module rv_execute (
    input  logic  clk_i,
    input  logic  rst_n_i,
    id_ex_if.dst  id,
    ex_mem_if.src mem
);
    import rv_core_pkg::*;

    xlen_t op_b;
    xlen_t alu_result;

    assign op_b = id.alu_use_imm ? id.imm : id.rs2_val;

    // Loads and stores arrive here as ALU_ADD for the address
    always_comb begin
        case (id.alu_op)
            ALU_SUB: alu_result = id.rs1_val - op_b;
            ALU_AND: alu_result = id.rs1_val & op_b;
            ALU_OR:  alu_result = id.rs1_val | op_b;
            ALU_XOR: alu_result = id.rs1_val ^ op_b;
            ALU_SLT: begin
                alu_result = ($signed(id.rs1_val) < $signed(op_b)) ? xlen_t'(1) : '0;
            end
            default: alu_result = id.rs1_val + op_b;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mem.reg_write <= 1'b0;
            mem.mem_read  <= 1'b0;
            mem.mem_write <= 1'b0;
        end else begin
            mem.reg_write <= id.reg_write;
            mem.mem_read  <= id.mem_read;
            mem.mem_write <= id.mem_write;
        end
    end

    always_ff @(posedge clk_i) begin
        mem.alu_result <= alu_result;
        mem.store_data <= id.rs2_val;
        mem.rd         <= id.rd;
    end

endmodule

//--- rv_decode.sv
// Decode stage: control decode, immediates, branch resolution, decode/execute register
`timescale 1ns/10ps

module rv_decode (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  rv_core_pkg::pc_t     pc_i,
    input  rv_core_pkg::instr_t  instr_i,
    output rv_core_pkg::rf_idx_t rs1_idx_o,
    output rv_core_pkg::rf_idx_t rs2_idx_o,
    input  rv_core_pkg::xlen_t   rs1_val_i,
    input  rv_core_pkg::xlen_t   rs2_val_i,
    output logic                 branch_taken_o,
    output rv_core_pkg::pc_t     branch_target_o,
    id_ex_if.src                 ex
);
    import rv_core_pkg::*;

    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    xlen_t      imm_i_type;
    xlen_t      imm_s_type;
    xlen_t      imm_b_type;

    alu_op_t    dec_alu_op;
    logic       dec_use_imm;
    xlen_t      dec_imm;
    logic       dec_reg_write;
    logic       dec_mem_read;
    logic       dec_mem_write;
    logic       is_beq;
    logic       is_bne;
    logic       rs_equal;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                         instr_i[30:25], instr_i[11:8], 1'b0};

    assign rs1_idx_o = instr_i[19:15];
    assign rs2_idx_o = instr_i[24:20];

    // Anything outside the subset leaves all enables low
    always_comb begin
        dec_alu_op    = ALU_ADD;
        dec_use_imm   = 1'b0;
        dec_imm       = imm_i_type;
        dec_reg_write = 1'b0;
        dec_mem_read  = 1'b0;
        dec_mem_write = 1'b0;
        is_beq        = 1'b0;
        is_bne        = 1'b0;
        case (opcode)
            OPC_OP: begin
                if (funct7 == 7'b0000000 || (funct7 == 7'b0100000 && funct3 == 3'b000)) begin
                    dec_reg_write = 1'b1;
                    case (funct3)
                        3'b000:  dec_alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
                        3'b010:  dec_alu_op = ALU_SLT;
                        3'b100:  dec_alu_op = ALU_XOR;
                        3'b110:  dec_alu_op = ALU_OR;
                        3'b111:  dec_alu_op = ALU_AND;
                        default: dec_reg_write = 1'b0;
                    endcase
                end
            end
            OPC_OP_IMM: begin
                dec_use_imm   = 1'b1;
                dec_reg_write = 1'b1;
                case (funct3)
                    3'b000:  dec_alu_op = ALU_ADD;
                    3'b100:  dec_alu_op = ALU_XOR;
                    3'b110:  dec_alu_op = ALU_OR;
                    3'b111:  dec_alu_op = ALU_AND;
                    default: dec_reg_write = 1'b0;
                endcase
            end
            OPC_LOAD: begin
                if (funct3 == 3'b010) begin
                    dec_use_imm   = 1'b1;
                    dec_mem_read  = 1'b1;
                    dec_reg_write = 1'b1;
                end
            end
            OPC_STORE: begin
                if (funct3 == 3'b010) begin
                    dec_use_imm   = 1'b1;
                    dec_imm       = imm_s_type;
                    dec_mem_write = 1'b1;
                end
            end
            OPC_BRANCH: begin
                is_beq = (funct3 == 3'b000);
                is_bne = (funct3 == 3'b001);
            end
            default: ;
        endcase
    end

    // Branches resolve here, one bubble on taken
    assign rs_equal        = (rs1_val_i == rs2_val_i);
    assign branch_taken_o  = (is_beq && rs_equal) || (is_bne && !rs_equal);
    assign branch_target_o = pc_i + imm_b_type;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex.reg_write <= 1'b0;
            ex.mem_read  <= 1'b0;
            ex.mem_write <= 1'b0;
        end else begin
            ex.reg_write <= dec_reg_write;
            ex.mem_read  <= dec_mem_read;
            ex.mem_write <= dec_mem_write;
        end
    end

    always_ff @(posedge clk_i) begin
        ex.alu_op      <= dec_alu_op;
        ex.alu_use_imm <= dec_use_imm;
        ex.rs1_val     <= rs1_val_i;
        ex.rs2_val     <= rs2_val_i;
        ex.imm         <= dec_imm;
        ex.rd          <= instr_i[11:7];
    end

endmodule

//--- rv_regfile.sv
// Integer register file: two combinational reads, one write port from writeback
`timescale 1ns/10ps

module rv_regfile (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  rv_core_pkg::rf_idx_t rs1_idx_i,
    input  rv_core_pkg::rf_idx_t rs2_idx_i,
    output rv_core_pkg::xlen_t   rs1_val_o,
    output rv_core_pkg::xlen_t   rs2_val_o,
    input  logic                 wb_we_i,
    input  rv_core_pkg::rf_idx_t wb_rd_i,
    input  rv_core_pkg::xlen_t   wb_data_i
);
    import rv_core_pkg::*;

    xlen_t regs_q [RF_DEPTH];
    logic  wr_en;

    // x0 is never written
    assign wr_en = wb_we_i && (wb_rd_i != '0);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < RF_DEPTH; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en) begin
            regs_q[wb_rd_i] <= wb_data_i;
        end
    end

    // Write-through so decode sees the value retiring this cycle
    assign rs1_val_o = (wr_en && wb_rd_i == rs1_idx_i) ? wb_data_i : regs_q[rs1_idx_i];
    assign rs2_val_o = (wr_en && wb_rd_i == rs2_idx_i) ? wb_data_i : regs_q[rs2_idx_i];

endmodule

//--- rv_fetch.sv
// Fetch stage: PC register, next-PC mux and the fetch/decode register
`timescale 1ns/10ps

module rv_fetch #(
    parameter rv_core_pkg::pc_t RESET_PC = '0
) (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                branch_taken_i,
    input  rv_core_pkg::pc_t    branch_target_i,
    output rv_core_pkg::pc_t    imem_addr_o,
    input  rv_core_pkg::instr_t imem_data_i,
    output rv_core_pkg::pc_t    pc_o,
    output rv_core_pkg::instr_t instr_o
);
    import rv_core_pkg::*;

    pc_t    pc_q;
    pc_t    pc_next;
    pc_t    if_id_pc_q;
    instr_t if_id_instr_q;

    // Redirect from decode wins over sequential fetch
    assign pc_next = branch_taken_i ? branch_target_i : pc_q + 32'd4;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    // Squash the wrong-path instruction behind a taken branch
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            if_id_instr_q <= NOP_INSTR;
        end else if (branch_taken_i) begin
            if_id_instr_q <= NOP_INSTR;
        end else begin
            if_id_instr_q <= imem_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if_id_pc_q <= pc_q;
    end

    assign imem_addr_o = pc_q;
    assign pc_o        = if_id_pc_q;
    assign instr_o     = if_id_instr_q;

endmodule

//--- rv_stage_if.sv
// Pipeline stage bundles: decode to execute, and execute to memory
`timescale 1ns/10ps

interface id_ex_if;
    import rv_core_pkg::*;

    alu_op_t alu_op;
    logic    alu_use_imm;
    xlen_t   rs1_val;
    xlen_t   rs2_val;
    xlen_t   imm;
    rf_idx_t rd;
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;

    modport src (
        output alu_op, alu_use_imm, rs1_val, rs2_val, imm, rd,
        output reg_write, mem_read, mem_write
    );

    modport dst (
        input alu_op, alu_use_imm, rs1_val, rs2_val, imm, rd,
        input reg_write, mem_read, mem_write
    );
endinterface

interface ex_mem_if;
    import rv_core_pkg::*;

    xlen_t   alu_result;
    xlen_t   store_data;
    rf_idx_t rd;
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;

    modport src (output alu_result, store_data, rd, reg_write, mem_read, mem_write);
    modport dst (input  alu_result, store_data, rd, reg_write, mem_read, mem_write);
endinterface

//--- rv_core_pkg.sv
// Shared widths, typedefs, opcodes and ALU codes, imported by every pipeline module
package rv_core_pkg;

    localparam int XLEN     = 32;
    localparam int RF_DEPTH = 32;

    typedef logic [XLEN-1:0]             xlen_t;
    typedef logic [XLEN-1:0]             pc_t;
    typedef logic [31:0]                 instr_t;
    typedef logic [$clog2(RF_DEPTH)-1:0] rf_idx_t;
    typedef logic [2:0]                  alu_op_t;
    typedef logic [6:0]                  opcode_t;

    // ALU operation codes
    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_SUB = 3'd1;
    localparam alu_op_t ALU_AND = 3'd2;
    localparam alu_op_t ALU_OR  = 3'd3;
    localparam alu_op_t ALU_XOR = 3'd4;
    localparam alu_op_t ALU_SLT = 3'd5;

    // Major opcodes of the supported subset
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;

    // addi x0, x0, 0
    localparam instr_t NOP_INSTR = 32'h0000_0013;

endpackage
